// File: hw/afi_mux_pkg.sv
package afi_mux_pkg;

    localparam int CHUNK_AW = 27;          // chunk address / start / length width
    localparam int NUM_CHN  = 4;           // compressor channels, encoders assume four

    // request level from one compressor channel
    typedef struct packed {
        logic       want;                  // channel has data ready for a burst
        logic [1:0] inc_want_m1;           // wanted chunks minus one
        logic       last;                  // this burst closes the frame
    } chn_req_t;

    // write port of the start/length RAM
    typedef struct packed {
        logic                we;           // write strobe
        logic [2:0]          wa;           // 0..3 start, 4..7 length
        logic [CHUNK_AW-1:0] di;           // value in chunks
    } sa_len_wr_t;

    // one write burst as handed to the bus side
    typedef struct packed {
        logic [31:0] byte_addr;            // chunk address * 32
        logic [2:0]  chunks;               // 1..4
        logic [1:0]  chn;                  // source channel
        logic        eof;                  // burst ends a frame
    } burst_cmd_t;

    localparam int CHN_REQ_W   = $bits(chn_req_t);
    localparam int SA_LEN_WR_W = $bits(sa_len_wr_t);
    localparam int BURST_CMD_W = $bits(burst_cmd_t);

endpackage

// File: hw/chunk_ptr_keeper.sv
`timescale 1ns/1ps

module chunk_ptr_keeper (
    input  logic                              hclk,
    input  logic                              start_resetting_w,
    input  logic                              en,                  // 0->1 clears all pointers
    input  afi_mux_pkg::sa_len_wr_t           sa_len_wr,
    input  logic [afi_mux_pkg::NUM_CHN-1:0]   reset_pointers,      // per channel clear request
    input  logic                              pre_busy_w,          // grant pulse
    input  logic [1:0]                        winner_channel,      // offered / granted channel
    input  logic                              need_to_bother,      // some channel wants a burst
    input  logic [1:0]                        chunk_inc_want_m1,   // wanted chunks - 1
    input  logic                              last_burst_in_frame,
    input  logic [3:0]                        busy,
    input  logic [2:0]                        chunk_ptr_ra,        // {frame, chn}
    output logic                              ptr_resetting,       // 2-cycle clear pulse
    output logic [afi_mux_pkg::CHUNK_AW-1:0]  chunk_addr,          // valid with busy[1]
    output logic [2:0]                        burst_chunks,        // granted length 1..4
    output logic [afi_mux_pkg::CHUNK_AW-1:0]  chunk_ptr_rd,
    output logic [2:0]                        max_wlen             // chunks to rollover - 1, clip 7
);
    import afi_mux_pkg::*;

    logic                en_d;               // en delayed, for rising edge
    logic [NUM_CHN-1:0]  reset_rq;           // channels waiting to be cleared
    logic [NUM_CHN-1:0]  reset_rq_pri;       // one-hot, channel being cleared
    logic [1:0]          reset_rq_enc;
    logic                clear_start_w;
    logic                keeper_idle;
    logic [1:0]          resetting;          // [0] current ptr phase, [1] delayed

    logic [CHUNK_AW-1:0] sa_len_ram [0:7];   // 0..3 starts, 4..7 lengths
    logic [CHUNK_AW-1:0] ptr_ram    [0:7];   // 0..3 current, 4..7 frame pointers
    logic [2:0]          max_inc_ram [0:NUM_CHN-1];

    logic [2:0]          ptr_wa;             // msb selects frame pointer
    logic                ptr_we;
    logic [CHUNK_AW-1:0] ptr_ram_di;
    logic [CHUNK_AW-1:0] ptr_old;
    logic [CHUNK_AW-1:0] buf_start;
    logic [CHUNK_AW-1:0] buf_len;
    logic [CHUNK_AW-1:0] chunks_to_rollover;
    logic [CHUNK_AW-1:0] chunk_ptr_inc;      // old pointer + granted length

    logic [1:0]          pre_chunk_inc_m1;   // granted length - 1 at the grant
    logic                rollover_w;
    logic                rollover_r;
    logic                frame_r;            // frame flag of the running burst

    logic [3:0]          rem_r;              // remaining chunks, [3] means >= 8
    logic [3:0]          rem_m1;
    logic                rem_we;
    logic [1:0]          rem_wa;
    logic                lim_we;
    logic [1:0]          lim_wa;
    logic [2:0]          lim_di;

    assign ptr_resetting = resetting[0];
    assign reset_rq_enc  = {reset_rq_pri[3] | reset_rq_pri[2],
                            reset_rq_pri[3] | reset_rq_pri[1]};

    // nothing in flight: no burst pipeline, no clear, no table update
    assign keeper_idle   = !(|busy) && (resetting == 2'b00) && !ptr_we && !rem_we && !lim_we;
    // never together with a grant, a grant needs need_to_bother
    assign clear_start_w = en && keeper_idle && (|reset_rq) && !need_to_bother;

    assign buf_start = sa_len_ram[{1'b0, ptr_wa[1:0]}];
    assign buf_len   = sa_len_ram[{1'b1, ptr_wa[1:0]}];
    assign ptr_old   = ptr_ram[{1'b0, ptr_wa[1:0]}];

    assign ptr_ram_di = (resetting[1] || rollover_r) ? '0 : chunk_ptr_inc;
    assign chunks_to_rollover = buf_len - ptr_ram_di;   // length after clear or wrap
    assign rem_m1 = rem_r - 4'd1;

    assign max_wlen     = max_inc_ram[winner_channel];  // read for the offered winner
    assign chunk_ptr_rd = ptr_ram[chunk_ptr_ra];        // status readback

    // want fits unless limit says fewer than four chunks left
    assign pre_chunk_inc_m1 = (max_wlen[2] || (max_wlen[1:0] >= chunk_inc_want_m1)) ?
                              chunk_inc_want_m1 : max_wlen[1:0];
    assign rollover_w = !max_wlen[2] && (max_wlen[1:0] <= chunk_inc_want_m1);

    always_ff @(posedge hclk) begin : mem_write
        if (sa_len_wr.we) begin
            sa_len_ram[sa_len_wr.wa] <= sa_len_wr.di;
        end
        if (ptr_we) begin
            ptr_ram[ptr_wa] <= ptr_ram_di;                // current, then frame if eof
        end
        if (lim_we) begin
            max_inc_ram[lim_wa] <= lim_di;
        end
    end

    always_ff @(posedge hclk) begin : ctrl
        if (start_resetting_w) begin
            en_d      <= 1'b0;
            reset_rq  <= '0;
            resetting <= 2'b00;
            ptr_we    <= 1'b0;
            rem_we    <= 1'b0;
            lim_we    <= 1'b0;
        end else begin
            en_d <= en;
            if (en && !en_d) begin
                reset_rq <= '1;                             // clear every channel on enable
            end else begin
                reset_rq <= reset_pointers |
                            (reset_rq & ~(reset_rq_pri & {NUM_CHN{resetting == 2'b01}}));
            end
            if (!en) begin
                resetting <= 2'b00;
            end else begin
                resetting <= {resetting[0], clear_start_w | (resetting[0] & ~resetting[1])};
            end
            ptr_we <= resetting[0] ||                        // both pointers of cleared chn
                      busy[1] ||                             // current pointer every burst
                      (busy[2] && frame_r);                  // frame pointer on eof
            rem_we <= ptr_we && !ptr_wa[2];                  // only current ptr moves limit
            lim_we <= rem_we;
        end
    end

    always_ff @(posedge hclk) begin : ptr_path
        if (clear_start_w) begin
            reset_rq_pri <= reset_rq & (~reset_rq + 4'd1);   // lowest index first
        end
        if (resetting == 2'b01) begin
            ptr_wa[1:0] <= reset_rq_enc;
        end else if (pre_busy_w) begin
            ptr_wa[1:0] <= winner_channel;
        end
        if (clear_start_w || pre_busy_w) begin
            ptr_wa[2] <= 1'b0;
        end else if (ptr_we) begin
            ptr_wa[2] <= 1'b1;                               // frame pointer next
        end
        if (pre_busy_w) begin
            burst_chunks <= {1'b0, pre_chunk_inc_m1} + 3'd1;
            rollover_r   <= rollover_w;
            frame_r      <= last_burst_in_frame;
        end
        if (busy[0] && !busy[1]) begin
            chunk_addr    <= buf_start + ptr_old;            // absolute chunk address
            chunk_ptr_inc <= ptr_old + {{(CHUNK_AW-3){1'b0}}, burst_chunks};
        end
        if (ptr_we && !ptr_wa[2]) begin
            rem_r  <= {|chunks_to_rollover[CHUNK_AW-1:3], chunks_to_rollover[2:0]};
            rem_wa <= ptr_wa[1:0];
        end
        if (rem_we) begin
            lim_wa <= rem_wa;
            lim_di <= rem_m1[3] ? 3'd7 : rem_m1[2:0];
        end
    end

endmodule

// File: hw/channel_arbiter.sv
`timescale 1ns/1ps

module channel_arbiter #(
    parameter int GRANT_GAP = 6                  // min cycles between grants, 6 or more
) (
    input  logic                                            hclk,
    input  logic                                            start_resetting_w,
    input  afi_mux_pkg::chn_req_t [afi_mux_pkg::NUM_CHN-1:0] chn_req,
    input  logic                                            ptr_resetting,
    output logic                                            pre_busy_w,      // grant pulse
    output logic [1:0]                                      winner_channel,
    output logic                                            need_to_bother,
    output logic [1:0]                                      inc_want_m1,
    output logic                                            last_burst_in_frame,
    output logic [3:0]                                      busy
);
    import afi_mux_pkg::*;

    localparam int GAP_W = $clog2(GRANT_GAP);

    logic [NUM_CHN-1:0] want_w;
    logic [1:0]         last_winner;         // round robin restarts after this one
    logic [1:0]         pick_w;
    logic               pick_valid_w;
    logic               offer_valid;         // winner_channel holds a real candidate
    logic               offer_free_w;
    logic [GAP_W-1:0]   gap_cnt;

    always_comb begin : want_vector
        for (int i = 0; i < NUM_CHN; i++) begin
            want_w[i] = chn_req[i].want;
        end
    end

    assign need_to_bother = |want_w;

    always_comb begin : rr_pick
        logic [1:0] idx;
        idx          = last_winner;
        pick_w       = last_winner;
        pick_valid_w = 1'b0;
        for (int i = 1; i <= NUM_CHN; i++) begin
            idx = last_winner + 2'(i);                       // wraps, last winner checked last
            if (!pick_valid_w && want_w[idx]) begin
                pick_w       = idx;
                pick_valid_w = 1'b1;
            end
        end
    end

    // offer is refreshed until one cycle before the gap runs out, then frozen
    // through the grant so keeper and builder see a stable winner
    assign offer_free_w = (gap_cnt <= GAP_W'(1)) && !pre_busy_w;

    // no grant while pointers are cleared; a clear only starts with no wants
    assign pre_busy_w = offer_valid && want_w[winner_channel] &&
                        (gap_cnt == '0) && !ptr_resetting;

    always_ff @(posedge hclk) begin : ctrl
        if (start_resetting_w) begin
            busy        <= 4'b0000;
            gap_cnt     <= '0;
            offer_valid <= 1'b0;
            last_winner <= 2'd3;                             // channel 0 goes first
        end else begin
            busy <= {busy[2:0], pre_busy_w};                 // busy[k] = grant delayed k+1
            if (pre_busy_w || ptr_resetting) begin
                gap_cnt <= GAP_W'(GRANT_GAP - 1);            // also spaces grant after clear
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - GAP_W'(1);
            end
            if (offer_free_w) begin
                offer_valid <= pick_valid_w;
            end
            if (pre_busy_w) begin
                last_winner <= winner_channel;
            end
        end
    end

    always_ff @(posedge hclk) begin : offer_regs
        if (offer_free_w) begin
            winner_channel      <= pick_w;
            inc_want_m1         <= chn_req[pick_w].inc_want_m1;
            last_burst_in_frame <= chn_req[pick_w].last;
        end
    end

endmodule

// File: hw/burst_cmd_builder.sv
`timescale 1ns/1ps

module burst_cmd_builder (
    input  logic                              hclk,
    input  logic                              start_resetting_w,
    input  logic [3:0]                        busy,
    input  logic [afi_mux_pkg::CHUNK_AW-1:0]  chunk_addr,          // valid with busy[1]
    input  logic [2:0]                        burst_chunks,
    input  logic [1:0]                        winner_channel,
    input  logic                              last_burst_in_frame,
    output logic                              cmd_valid,           // grant + 3
    output afi_mux_pkg::burst_cmd_t           cmd,
    output logic [afi_mux_pkg::NUM_CHN-1:0]   frame_done           // one-hot, with cmd_valid
);
    import afi_mux_pkg::*;

    logic [1:0]          chn_s0;             // winner taken early in the pipeline
    logic                eof_s0;
    logic [CHUNK_AW-1:0] addr_r;
    logic [2:0]          chunks_r;
    logic [1:0]          chn_r;
    logic                eof_r;

    always_ff @(posedge hclk) begin : hold_pipe
        if (busy[0] && !busy[1]) begin
            chn_s0 <= winner_channel;
            eof_s0 <= last_burst_in_frame;
        end
        if (busy[1] && !busy[2]) begin               // keeper address just became valid
            addr_r   <= chunk_addr;
            chunks_r <= burst_chunks;
            chn_r    <= chn_s0;
            eof_r    <= eof_s0;
        end
    end

    always_ff @(posedge hclk) begin : frame_pulse
        if (start_resetting_w) begin
            frame_done <= '0;
        end else if (busy[1] && !busy[2] && eof_s0) begin
            frame_done <= NUM_CHN'(1) << chn_s0;     // lines up with cmd_valid
        end else begin
            frame_done <= '0;
        end
    end

    assign cmd_valid = busy[2] && !busy[3];          // single cycle per burst

    always_comb begin : cmd_pack
        cmd.byte_addr = {addr_r, 5'b00000};          // 32-byte chunks
        cmd.chunks    = chunks_r;
        cmd.chn       = chn_r;
        cmd.eof       = eof_r;
    end

endmodule

// File: hw/afi_mux_top.sv
`timescale 1ns/1ps

module afi_mux_top #(
    parameter int GRANT_GAP = 6
) (
    input  logic                                            hclk,
    input  logic                                            start_resetting_w,
    input  logic                                            en,
    input  afi_mux_pkg::sa_len_wr_t                         sa_len_wr,
    input  logic [afi_mux_pkg::NUM_CHN-1:0]                 reset_pointers,
    input  afi_mux_pkg::chn_req_t [afi_mux_pkg::NUM_CHN-1:0] chn_req,
    input  logic [2:0]                                      chunk_ptr_ra,
    output logic                                            cmd_valid,
    output afi_mux_pkg::burst_cmd_t                         cmd,
    output logic [afi_mux_pkg::NUM_CHN-1:0]                 frame_done,
    output logic [afi_mux_pkg::CHUNK_AW-1:0]                chunk_ptr_rd
);
    import afi_mux_pkg::*;

    logic                pre_busy_w;
    logic [1:0]          winner_channel;
    logic                need_to_bother;
    logic [1:0]          inc_want_m1;
    logic                last_burst_in_frame;
    logic [3:0]          busy;
    logic                ptr_resetting;
    logic [CHUNK_AW-1:0] chunk_addr;
    logic [2:0]          burst_chunks;

    channel_arbiter #(
        .GRANT_GAP (GRANT_GAP)
    ) u_arbiter (
        .hclk                (hclk),
        .start_resetting_w   (start_resetting_w),
        .chn_req             (chn_req),
        .ptr_resetting       (ptr_resetting),
        .pre_busy_w          (pre_busy_w),
        .winner_channel      (winner_channel),
        .need_to_bother      (need_to_bother),
        .inc_want_m1         (inc_want_m1),
        .last_burst_in_frame (last_burst_in_frame),
        .busy                (busy)
    );

    chunk_ptr_keeper u_keeper (
        .hclk                (hclk),
        .start_resetting_w   (start_resetting_w),
        .en                  (en),
        .sa_len_wr           (sa_len_wr),
        .reset_pointers      (reset_pointers),
        .pre_busy_w          (pre_busy_w),
        .winner_channel      (winner_channel),
        .need_to_bother      (need_to_bother),
        .chunk_inc_want_m1   (inc_want_m1),
        .last_burst_in_frame (last_burst_in_frame),
        .busy                (busy),
        .chunk_ptr_ra        (chunk_ptr_ra),
        .ptr_resetting       (ptr_resetting),
        .chunk_addr          (chunk_addr),
        .burst_chunks        (burst_chunks),
        .chunk_ptr_rd        (chunk_ptr_rd),
        .max_wlen            ()
    );

    burst_cmd_builder u_builder (
        .hclk                (hclk),
        .start_resetting_w   (start_resetting_w),
        .busy                (busy),
        .chunk_addr          (chunk_addr),
        .burst_chunks        (burst_chunks),
        .winner_channel      (winner_channel),
        .last_burst_in_frame (last_burst_in_frame),
        .cmd_valid           (cmd_valid),
        .cmd                 (cmd),
        .frame_done          (frame_done)
    );

endmodule

// File: verif/afi_mux_tb.sv
`timescale 1ns/1ps

module afi_mux_tb;
    import afi_mux_pkg::*;

    localparam int TIMEOUT = 200;                    // cycles allowed for any single wait

    logic                   hclk;
    logic                   start_resetting_w;
    logic                   en;
    sa_len_wr_t             sa_len_wr;
    logic [NUM_CHN-1:0]     reset_pointers;
    chn_req_t [NUM_CHN-1:0] chn_req;
    logic [2:0]             chunk_ptr_ra;
    logic                   cmd_valid;
    burst_cmd_t             cmd;
    logic [NUM_CHN-1:0]     frame_done;
    logic [CHUNK_AW-1:0]    chunk_ptr_rd;

    int unsigned buf_start [NUM_CHN];                // model of each circular buffer
    int unsigned buf_len   [NUM_CHN];
    int unsigned cur_ptr   [NUM_CHN];
    int unsigned frm_ptr   [NUM_CHN];
    int unsigned last_winner;                        // round robin resumes after this one
    int          errors;

    afi_mux_top #(
        .GRANT_GAP (6)
    ) DUT (
        .hclk              (hclk),
        .start_resetting_w (start_resetting_w),
        .en                (en),
        .sa_len_wr         (sa_len_wr),
        .reset_pointers    (reset_pointers),
        .chn_req           (chn_req),
        .chunk_ptr_ra      (chunk_ptr_ra),
        .cmd_valid         (cmd_valid),
        .cmd               (cmd),
        .frame_done        (frame_done),
        .chunk_ptr_rd      (chunk_ptr_rd)
    );

    always #10 hclk = ~hclk;                         // 20 ns period

    task automatic report_mismatch(input string test, input string field,
                                   input int unsigned exp, input int unsigned act);
        $display("FAIL %s %s: expected %0h actual %0h", test, field, exp, act);
        errors++;
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        $display("errors: %0d", errors);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic write_sa_len(input int unsigned wa, input int unsigned val);
        @(negedge hclk);
        sa_len_wr.we = 1'b1;
        sa_len_wr.wa = 3'(wa);
        sa_len_wr.di = CHUNK_AW'(val);
        @(negedge hclk);
        sa_len_wr.we = 1'b0;
    endtask

    task automatic read_ptr(input int unsigned ra, output int unsigned val);
        @(negedge hclk);
        chunk_ptr_ra = 3'(ra);
        @(negedge hclk);                             // combinational read has settled by now
        val = 32'(chunk_ptr_rd);
    endtask

    task automatic check_ptrs(input string test);
        int unsigned val;
        for (int ch = 0; ch < NUM_CHN; ch++) begin
            read_ptr(ch, val);
            if (val != cur_ptr[ch]) report_mismatch(test, "current ptr", cur_ptr[ch], val);
            read_ptr(NUM_CHN + ch, val);
            if (val != frm_ptr[ch]) report_mismatch(test, "frame ptr", frm_ptr[ch], val);
        end
    endtask

    // counts completed clear pulses seen on the keeper output
    task automatic wait_clear_pulses(input int n);
        int   cycles;
        int   falls;
        logic prev;
        cycles = 0;
        falls  = 0;
        prev   = DUT.ptr_resetting;
        while (falls < n) begin
            @(negedge hclk);
            if (prev && !DUT.ptr_resetting) falls++;
            prev = DUT.ptr_resetting;
            cycles++;
            if (falls < n && cycles >= TIMEOUT) timeout_abort("pointer clear");
        end
    endtask

    task automatic wait_cmd(input string what, output burst_cmd_t c,
                            output logic [NUM_CHN-1:0] fd);
        int cycles;
        cycles = 0;
        @(negedge hclk);
        while (!cmd_valid) begin
            cycles++;
            if (cycles >= TIMEOUT) timeout_abort(what);
            @(negedge hclk);
        end
        c  = cmd;                                    // single cycle pulse so grab it now
        fd = frame_done;
    endtask

    // compare one command with the buffer rules and advance the model
    task automatic check_cmd(input string test, input int unsigned ch, input int unsigned want,
                             input bit last, input burst_cmd_t c,
                             input logic [NUM_CHN-1:0] fd);
        int unsigned        rem;
        int unsigned        exp_chunks;
        int unsigned        exp_addr;
        logic [NUM_CHN-1:0] exp_fd;
        rem        = buf_len[ch] - cur_ptr[ch];      // chunks left before wrap
        exp_chunks = (want < rem) ? want : rem;
        exp_addr   = (buf_start[ch] + cur_ptr[ch]) * 32;
        exp_fd     = last ? (NUM_CHN'(1) << ch) : '0;
        if (32'(c.chn) != ch) report_mismatch(test, "chn", ch, 32'(c.chn));
        if (c.byte_addr != exp_addr) report_mismatch(test, "byte_addr", exp_addr, c.byte_addr);
        if (32'(c.chunks) != exp_chunks) begin
            report_mismatch(test, "chunks", exp_chunks, 32'(c.chunks));
        end
        if (c.eof != last) report_mismatch(test, "eof", 32'(last), 32'(c.eof));
        if (fd != exp_fd) report_mismatch(test, "frame_done", 32'(exp_fd), 32'(fd));
        cur_ptr[ch] = (exp_chunks == rem) ? 0 : cur_ptr[ch] + exp_chunks;
        if (last) frm_ptr[ch] = cur_ptr[ch];
        last_winner = ch;
    endtask

    task automatic run_burst(input string test, input int unsigned ch,
                             input int unsigned want, input bit last);
        burst_cmd_t         c;
        logic [NUM_CHN-1:0] fd;
        @(negedge hclk);
        chn_req[ch].want        = 1'b1;
        chn_req[ch].inc_want_m1 = 2'(want - 1);
        chn_req[ch].last        = last;
        wait_cmd(test, c, fd);
        chn_req[ch].want = 1'b0;                     // one burst per request
        check_cmd(test, ch, want, last, c, fd);
    endtask

    task automatic setup_buffers();
        int unsigned starts [NUM_CHN] = '{'h100, 'h2000, 'h3_0000, 'h7F_0000};
        int unsigned lens   [NUM_CHN] = '{10, 37, 6, 3};
        for (int ch = 0; ch < NUM_CHN; ch++) begin
            write_sa_len(ch, starts[ch]);
            write_sa_len(NUM_CHN + ch, lens[ch]);    // lengths before en rises
            buf_start[ch] = starts[ch];
            buf_len[ch]   = lens[ch];
            cur_ptr[ch]   = 0;
            frm_ptr[ch]   = 0;
        end
        @(negedge hclk);
        en = 1'b1;
        wait_clear_pulses(NUM_CHN);                  // one pulse per channel
    endtask

    task automatic single_channel_test();
        int unsigned val;
        for (int i = 0; i < 6; i++) begin
            run_burst("single_channel", 1, 1 + ($urandom % 4), i == 5);
            read_ptr(1, val);
            if (val != cur_ptr[1]) begin
                report_mismatch("single_channel", "current ptr", cur_ptr[1], val);
            end
        end
    endtask

    task automatic rollover_test();
        int unsigned val;
        for (int i = 0; i < 3; i++) begin
            run_burst("rollover", 0, 4, 1'b0);       // 4, 4, then 2 of 10
        end
        read_ptr(0, val);
        if (val != 0) report_mismatch("rollover", "current ptr", 0, val);
    endtask

    task automatic frame_ptr_test();
        int unsigned val;
        run_burst("frame_ptr", 2, 2, 1'b1);
        read_ptr(NUM_CHN + 2, val);
        if (val != cur_ptr[2]) report_mismatch("frame_ptr", "frame ptr", cur_ptr[2], val);
        run_burst("frame_ptr", 2, 1, 1'b0);          // frame ptr must hold
        check_ptrs("frame_ptr");
    endtask

    task automatic fairness_clear_test();
        burst_cmd_t         c;
        logic [NUM_CHN-1:0] fd;
        int unsigned        exp_ch;
        @(negedge hclk);
        for (int ch = 0; ch < NUM_CHN; ch++) begin
            chn_req[ch].want        = 1'b1;
            chn_req[ch].inc_want_m1 = 2'd0;
            chn_req[ch].last        = 1'b0;
        end
        for (int i = 0; i < 2 * NUM_CHN; i++) begin
            exp_ch = (last_winner + 1) % NUM_CHN;    // everyone requesting
            wait_cmd("fairness", c, fd);
            check_cmd("fairness", exp_ch, 1, 1'b0, c, fd);
        end
        chn_req = '0;
        check_ptrs("fairness");
        @(negedge hclk);
        reset_pointers = 4'b0010;
        @(negedge hclk);
        reset_pointers = 4'b0000;
        wait_clear_pulses(1);
        cur_ptr[1] = 0;
        frm_ptr[1] = 0;
        @(negedge hclk);
        check_ptrs("channel_clear");                 // others keep their pointers
    endtask

    task automatic enable_clear_test();
        @(negedge hclk);
        en = 1'b0;
        @(negedge hclk);
        en = 1'b1;                                   // new rising edge with pointers in use
        wait_clear_pulses(NUM_CHN);
        for (int ch = 0; ch < NUM_CHN; ch++) begin
            cur_ptr[ch] = 0;
            frm_ptr[ch] = 0;
        end
        @(negedge hclk);
        check_ptrs("enable_clear");
    endtask

    initial begin
        hclk              = 1'b0;
        start_resetting_w = 1'b1;
        en                = 1'b0;
        sa_len_wr         = '0;
        reset_pointers    = '0;
        chn_req           = '0;
        chunk_ptr_ra      = '0;
        errors            = 0;
        last_winner       = NUM_CHN - 1;             // channel 0 wins first
        void'($urandom(91));
        repeat (16) @(negedge hclk);
        start_resetting_w = 1'b0;
        setup_buffers();
        single_channel_test();
        rollover_test();
        frame_ptr_test();
        fairness_clear_test();
        enable_clear_test();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: filelist.f
hw/afi_mux_pkg.sv
hw/chunk_ptr_keeper.sv
hw/channel_arbiter.sv
hw/burst_cmd_builder.sv
hw/afi_mux_top.sv
verif/afi_mux_tb.sv

// File: Makefile
TOP = afi_mux_tb

.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f filelist.f --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
